// ==== rv32iPkg.sv ====
package rv32iPkg;

    // ========================================
    // widths fixed by the ISA
    // ========================================
    localparam int xlen     = 32;
    localparam int regAddrW = 5;

    // ========================================
    // major opcodes
    // ========================================
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // ALU operations, PASSB hands operand B straight through for LUI
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_PASSB = 4'd10
    } aluOp_e;

    // operand selection for the execute stage
    typedef enum logic [1:0] {
        SRC_RS1_RS2   = 2'd0,
        SRC_RS1_IMM2  = 2'd1,
        SRC_IMM1_IMM2 = 2'd2,
        // link value for JAL and JALR
        SRC_PC_FOUR   = 2'd3
    } aluSrc_e;

    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_COND = 2'd1,
        BR_JAL  = 2'd2,
        BR_JALR = 2'd3
    } branchKind_e;

    // same encoding as funct3 of loads and stores
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101
    } memOp_e;

    // ========================================
    // decoded control and stage output
    // ========================================
    typedef struct packed {
        aluSrc_e     aluSrcSel;
        aluOp_e      aluOp;
        branchKind_e branchKind;
        // inverts the compare result, funct3 bit 0
        logic        branchNeg;
        logic        memWrEn;
        logic        memRdEn;
        logic        regWrEn;
        logic        memToReg;
        logic        jump;
        memOp_e      memOp;
    } decodeCtrl_t;

    typedef struct packed {
        logic [xlen-1:0]     pc;
        decodeCtrl_t         ctrl;
        logic [xlen-1:0]     pcDest;
        logic [xlen-1:0]     imm1;
        logic [xlen-1:0]     imm2;
        logic [xlen-1:0]     rs1Data;
        logic [xlen-1:0]     rs2Data;
        logic [regAddrW-1:0] rdAddr;
        logic [regAddrW-1:0] rs1Addr;
        logic [regAddrW-1:0] rs2Addr;
        logic                exception;
    } idOut_t;

endpackage

// ==== idControl.sv ====
module idControl (
    input  logic [rv32iPkg::xlen-1:0]     instr_i,
    input  logic [rv32iPkg::xlen-1:0]     pc_i,
    output rv32iPkg::decodeCtrl_t         ctrl_o,
    output logic [rv32iPkg::regAddrW-1:0] rdAddr_o,
    output logic [rv32iPkg::regAddrW-1:0] rs1Addr_o,
    output logic [rv32iPkg::regAddrW-1:0] rs2Addr_o,
    output logic [rv32iPkg::xlen-1:0]     imm1_o,
    output logic [rv32iPkg::xlen-1:0]     imm2_o,
    output logic                          illegal_o
);
    import rv32iPkg::*;

    // ========================================
    // instruction fields
    // ========================================
    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [regAddrW-1:0] rdField;
    logic [regAddrW-1:0] rs1Field;
    logic [regAddrW-1:0] rs2Field;
    logic [xlen-1:0]     immI;
    logic [xlen-1:0]     immS;
    logic [xlen-1:0]     immB;
    logic [xlen-1:0]     immU;
    logic [xlen-1:0]     immJ;

    assign opcode   = instr_i[6:0];
    assign funct3   = instr_i[14:12];
    assign funct7   = instr_i[31:25];
    assign rdField  = instr_i[11:7];
    assign rs1Field = instr_i[19:15];
    assign rs2Field = instr_i[24:20];

    // sign-extended immediates per format
    assign immI = {{20{instr_i[31]}}, instr_i[31:20]};
    assign immS = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign immB = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                   instr_i[11:8], 1'b0};
    assign immU = {instr_i[31:12], 12'b0};
    assign immJ = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                   instr_i[30:21], 1'b0};

    // funct3 to ALU op for register and immediate arithmetic
    function automatic aluOp_e arithOp(input logic [2:0] f3, input logic alt);
        aluOp_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // ========================================
    // main decode
    // ========================================
    always_comb begin
        ctrl_o    = '0;
        rdAddr_o  = '0;
        rs1Addr_o = '0;
        rs2Addr_o = '0;
        imm1_o    = '0;
        imm2_o    = '0;
        // every listed opcode ends in 2'b11, anything else falls to default
        illegal_o = (instr_i[1:0] != 2'b11);

        case (opcode)
            OPC_OP: begin
                illegal_o = illegal_o || !((funct7 == 7'b0000000) ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
                ctrl_o.aluSrcSel = SRC_RS1_RS2;
                ctrl_o.aluOp     = arithOp(funct3, funct7[5]);
                ctrl_o.regWrEn   = 1'b1;
                rdAddr_o         = rdField;
                rs1Addr_o        = rs1Field;
                rs2Addr_o        = rs2Field;
            end
            OPC_OP_IMM: begin
                // shift encodings constrain the upper immediate bits
                if (funct3 == 3'b001) begin
                    illegal_o = illegal_o || (funct7 != 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    illegal_o = illegal_o ||
                        !(funct7 == 7'b0000000 || funct7 == 7'b0100000);
                end
                ctrl_o.aluSrcSel = SRC_RS1_IMM2;
                ctrl_o.aluOp     = arithOp(funct3, (funct3 == 3'b101) && funct7[5]);
                ctrl_o.regWrEn   = 1'b1;
                rdAddr_o         = rdField;
                rs1Addr_o        = rs1Field;
                imm2_o           = immI;
            end
            OPC_LOAD: begin
                illegal_o = illegal_o || (funct3 == 3'b011) ||
                    (funct3 == 3'b110) || (funct3 == 3'b111);
                ctrl_o.aluSrcSel = SRC_RS1_IMM2;
                ctrl_o.aluOp     = ALU_ADD;
                ctrl_o.memRdEn   = 1'b1;
                ctrl_o.regWrEn   = 1'b1;
                ctrl_o.memToReg  = 1'b1;
                ctrl_o.memOp     = memOp_e'(funct3);
                rdAddr_o         = rdField;
                rs1Addr_o        = rs1Field;
                imm2_o           = immI;
            end
            OPC_STORE: begin
                illegal_o = illegal_o || (funct3[2] || funct3 == 3'b011);
                ctrl_o.aluSrcSel = SRC_RS1_IMM2;
                ctrl_o.aluOp     = ALU_ADD;
                ctrl_o.memWrEn   = 1'b1;
                ctrl_o.memOp     = memOp_e'(funct3);
                rs1Addr_o        = rs1Field;
                rs2Addr_o        = rs2Field;
                imm2_o           = immS;
            end
            OPC_BRANCH: begin
                illegal_o = illegal_o || (funct3 == 3'b010) || (funct3 == 3'b011);
                ctrl_o.aluSrcSel  = SRC_RS1_RS2;
                // eq/ne via subtract, signed and unsigned compares otherwise
                ctrl_o.aluOp      = !funct3[2] ? ALU_SUB : (funct3[1] ? ALU_SLTU : ALU_SLT);
                ctrl_o.branchKind = BR_COND;
                ctrl_o.branchNeg  = funct3[0];
                rs1Addr_o         = rs1Field;
                rs2Addr_o         = rs2Field;
                imm2_o            = immB;
            end
            OPC_JAL: begin
                ctrl_o.aluSrcSel  = SRC_PC_FOUR;
                ctrl_o.aluOp      = ALU_ADD;
                ctrl_o.branchKind = BR_JAL;
                ctrl_o.regWrEn    = 1'b1;
                ctrl_o.jump       = 1'b1;
                rdAddr_o          = rdField;
                imm1_o            = pc_i;
                imm2_o            = immJ;
            end
            OPC_JALR: begin
                illegal_o = illegal_o || (funct3 != 3'b000);
                ctrl_o.aluSrcSel  = SRC_PC_FOUR;
                ctrl_o.aluOp      = ALU_ADD;
                ctrl_o.branchKind = BR_JALR;
                ctrl_o.regWrEn    = 1'b1;
                ctrl_o.jump       = 1'b1;
                rdAddr_o          = rdField;
                rs1Addr_o         = rs1Field;
                imm1_o            = pc_i;
                imm2_o            = immI;
            end
            OPC_LUI: begin
                ctrl_o.aluSrcSel = SRC_IMM1_IMM2;
                ctrl_o.aluOp     = ALU_PASSB;
                ctrl_o.regWrEn   = 1'b1;
                rdAddr_o         = rdField;
                imm2_o           = immU;
            end
            OPC_AUIPC: begin
                ctrl_o.aluSrcSel = SRC_IMM1_IMM2;
                ctrl_o.aluOp     = ALU_ADD;
                ctrl_o.regWrEn   = 1'b1;
                rdAddr_o         = rdField;
                imm1_o           = pc_i;
                imm2_o           = immU;
            end
            // system, fence and unknown opcodes
            default: illegal_o = 1'b1;
        endcase

        // illegal instruction becomes a NOP carrying the exception
        if (illegal_o) begin
            ctrl_o    = '0;
            rdAddr_o  = '0;
            rs1Addr_o = '0;
            rs2Addr_o = '0;
            imm1_o    = '0;
            imm2_o    = '0;
        end
    end

endmodule

// ==== idRegFile.sv ====
module idRegFile #(
    parameter int numRegs = 32
) (
    input  logic                          Clk,
    input  logic                          rstN_i,
    input  logic [rv32iPkg::regAddrW-1:0] rs1Addr_i,
    input  logic [rv32iPkg::regAddrW-1:0] rs2Addr_i,
    input  logic [rv32iPkg::regAddrW-1:0] rdAddr_i,
    input  logic [rv32iPkg::xlen-1:0]     rdData_i,
    input  logic                          rdWrEn_i,
    output logic [rv32iPkg::xlen-1:0]     rs1Data_o,
    output logic [rv32iPkg::xlen-1:0]     rs2Data_o
);
    import rv32iPkg::*;

    localparam int idxW = $clog2(numRegs);

    logic [xlen-1:0] regs [numRegs];

    // x0 reads zero, a same-cycle write is forwarded
    function automatic logic [xlen-1:0] readPort(input logic [regAddrW-1:0] addr);
        logic [xlen-1:0] data;
        if (addr == '0 || int'(addr) >= numRegs) begin
            data = '0;
        end else if (rdWrEn_i && rdAddr_i == addr) begin
            data = rdData_i;
        end else begin
            data = regs[addr[idxW-1:0]];
        end
        return data;
    endfunction

    always_comb begin
        rs1Data_o = readPort(rs1Addr_i);
        rs2Data_o = readPort(rs2Addr_i);
    end

    always_ff @(posedge Clk) begin
        if (!rstN_i) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (rdWrEn_i && rdAddr_i != '0 && int'(rdAddr_i) < numRegs) begin
            regs[rdAddr_i[idxW-1:0]] <= rdData_i;
        end
    end

endmodule

// ==== branchTargetGen.sv ====
module branchTargetGen (
    input  rv32iPkg::branchKind_e     kind_i,
    input  logic [rv32iPkg::xlen-1:0] pc_i,
    input  logic [rv32iPkg::xlen-1:0] rs1Data_i,
    input  logic [rv32iPkg::xlen-1:0] imm_i,
    output logic [rv32iPkg::xlen-1:0] dest_o
);
    import rv32iPkg::*;

    logic            isJalr;
    logic [xlen-1:0] base;
    logic [xlen-1:0] sum;

    assign isJalr = (kind_i == BR_JALR);

    // register-relative only for JALR
    assign base = isJalr ? rs1Data_i : pc_i;
    assign sum  = base + imm_i;

    // JALR target has its low bit forced to zero
    assign dest_o = isJalr ? {sum[xlen-1:1], 1'b0} : sum;

endmodule

// ==== idStage.sv ====
module idStage #(
    parameter int numRegs = 32
) (
    input  logic                          Clk,
    input  logic                          rstN_i,
    // fetch
    input  logic [rv32iPkg::xlen-1:0]     ifPc_i,
    input  logic [rv32iPkg::xlen-1:0]     ifInstr_i,
    // hazard control
    input  logic                          idStall_i,
    input  logic                          idFlush_i,
    // write-back port
    input  logic [rv32iPkg::regAddrW-1:0] wbRdAddr_i,
    input  logic [rv32iPkg::xlen-1:0]     wbRdData_i,
    input  logic                          wbRegWrEn_i,
    // ID/EX register
    output rv32iPkg::idOut_t              idOut_o
);
    import rv32iPkg::*;

    // ========================================
    // decode results
    // ========================================
    decodeCtrl_t         decCtrl;
    logic [regAddrW-1:0] decRdAddr;
    logic [regAddrW-1:0] decRs1Addr;
    logic [regAddrW-1:0] decRs2Addr;
    logic [xlen-1:0]     decImm1;
    logic [xlen-1:0]     decImm2;
    logic                decIllegal;
    logic [xlen-1:0]     rs1Data;
    logic [xlen-1:0]     rs2Data;
    logic [xlen-1:0]     pcDest;
    idOut_t              idNext;

    // ========================================
    // instances
    // ========================================
    idControl u_control (
        .instr_i   (ifInstr_i),
        .pc_i      (ifPc_i),
        .ctrl_o    (decCtrl),
        .rdAddr_o  (decRdAddr),
        .rs1Addr_o (decRs1Addr),
        .rs2Addr_o (decRs2Addr),
        .imm1_o    (decImm1),
        .imm2_o    (decImm2),
        .illegal_o (decIllegal)
    );

    // read with the incoming instruction's source addresses
    idRegFile #(
        .numRegs (numRegs)
    ) u_regFile (
        .Clk       (Clk),
        .rstN_i    (rstN_i),
        .rs1Addr_i (decRs1Addr),
        .rs2Addr_i (decRs2Addr),
        .rdAddr_i  (wbRdAddr_i),
        .rdData_i  (wbRdData_i),
        .rdWrEn_i  (wbRegWrEn_i),
        .rs1Data_o (rs1Data),
        .rs2Data_o (rs2Data)
    );

    branchTargetGen u_target (
        .kind_i    (decCtrl.branchKind),
        .pc_i      (ifPc_i),
        .rs1Data_i (rs1Data),
        .imm_i     (decImm2),
        .dest_o    (pcDest)
    );

    // ========================================
    // next ID/EX contents
    // ========================================
    always_comb begin
        idNext.pc        = ifPc_i;
        idNext.ctrl      = decCtrl;
        idNext.pcDest    = pcDest;
        idNext.imm1      = decImm1;
        idNext.imm2      = decImm2;
        idNext.rs1Data   = rs1Data;
        idNext.rs2Data   = rs2Data;
        idNext.rdAddr    = decRdAddr;
        idNext.rs1Addr   = decRs1Addr;
        idNext.rs2Addr   = decRs2Addr;
        idNext.exception = decIllegal;
    end

    // ========================================
    // ID/EX pipeline register
    // ========================================
    always_ff @(posedge Clk) begin
        // reset and flush both load a NOP, flush beats stall
        if (!rstN_i || idFlush_i) begin
            idOut_o <= '0;
        end else if (idStall_i) begin
            // hold the slot but strip anything with side effects
            idOut_o.ctrl.memWrEn  <= 1'b0;
            idOut_o.ctrl.memRdEn  <= 1'b0;
            idOut_o.ctrl.regWrEn  <= 1'b0;
            idOut_o.ctrl.memToReg <= 1'b0;
            idOut_o.ctrl.jump     <= 1'b0;
            idOut_o.ctrl.memOp    <= memOp_e'(3'b000);
        end else begin
            idOut_o <= idNext;
        end
    end

endmodule

// ==== tbIdModel.svh ====
`ifndef TB_ID_MODEL_SVH
`define TB_ID_MODEL_SVH

// ========================================
// instruction encoders
// ========================================
function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                    input logic [4:0] rs1, input logic [2:0] f3,
                                    input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
endfunction

function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                    input logic [2:0] f3, input logic [4:0] rd,
                                    input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

// ========================================
// shadow register file
// ========================================
logic [31:0] shadowRegs [32];

// ALU op by funct3 before the funct7 alternates
aluOp_e opTab [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};

// same-cycle write-back wins and x0 stays zero
function automatic logic [31:0] shadowRead(input logic [4:0] addr, input logic wbEn,
                                          input logic [4:0] wbA, input logic [31:0] wbD);
    logic [31:0] v;
    v = shadowRegs[addr];
    if (wbEn && wbA == addr) begin
        v = wbD;
    end
    if (addr == 5'd0) begin
        v = 32'h0;
    end
    return v;
endfunction

function automatic void shadowWrite(input logic wbEn, input logic [4:0] wbA,
                                    input logic [31:0] wbD);
    if (wbEn && wbA != 5'd0) begin
        shadowRegs[wbA] = wbD;
    end
endfunction

// ========================================
// expected ID/EX contents for one slot
// ========================================
function automatic idOut_t refDecode(input logic [31:0] ins, input logic [31:0] pc,
                                     input logic stall, input logic flush,
                                     input idOut_t prev, input logic wbEn,
                                     input logic [4:0] wbA, input logic [31:0] wbD);
    idOut_t      r;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        bad;
    logic        useRd;
    logic        useRs1;
    logic        useRs2;
    logic [31:0] immI;
    r      = '0;
    f3     = ins[14:12];
    f7     = ins[31:25];
    bad    = 1'b0;
    useRd  = 1'b1;
    useRs1 = 1'b1;
    useRs2 = 1'b0;
    immI   = 32'($signed(ins[31:20]));
    if (flush) begin
        return r;
    end
    // stalled slot repeats with its side effects removed
    if (stall) begin
        r = prev;
        r.ctrl.memWrEn  = 1'b0;
        r.ctrl.memRdEn  = 1'b0;
        r.ctrl.regWrEn  = 1'b0;
        r.ctrl.memToReg = 1'b0;
        r.ctrl.jump     = 1'b0;
        r.ctrl.memOp    = memOp_e'(3'b000);
        return r;
    end
    case (ins[6:0])
        7'h33: begin
            bad = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
            r.ctrl.aluOp = f7[5] ? (f3 == 3'd0 ? ALU_SUB : ALU_SRA) : opTab[f3];
            useRs2 = 1'b1;
        end
        7'h13: begin
            bad = (f3 == 3'd1 && f7 != 7'h00) ||
                  (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
            r.ctrl.aluSrcSel = SRC_RS1_IMM2;
            r.ctrl.aluOp     = (f3 == 3'd5 && f7[5]) ? ALU_SRA : opTab[f3];
            r.imm2           = immI;
        end
        7'h03: begin
            bad = (f3 == 3'd3) || (f3 > 3'd5);
            r.ctrl.aluSrcSel = SRC_RS1_IMM2;
            r.ctrl.memRdEn   = 1'b1;
            r.ctrl.memToReg  = 1'b1;
            r.ctrl.memOp     = memOp_e'(f3);
            r.imm2           = immI;
        end
        7'h23: begin
            bad    = (f3 > 3'd2);
            useRd  = 1'b0;
            useRs2 = 1'b1;
            r.ctrl.aluSrcSel = SRC_RS1_IMM2;
            r.ctrl.memWrEn   = 1'b1;
            r.ctrl.memOp     = memOp_e'(f3);
            r.imm2           = 32'($signed({ins[31:25], ins[11:7]}));
        end
        7'h63: begin
            bad    = (f3 == 3'd2) || (f3 == 3'd3);
            useRd  = 1'b0;
            useRs2 = 1'b1;
            // beq/bne subtract and the signed and unsigned pairs compare
            case (f3)
                3'd0, 3'd1: r.ctrl.aluOp = ALU_SUB;
                3'd4, 3'd5: r.ctrl.aluOp = ALU_SLT;
                default:    r.ctrl.aluOp = ALU_SLTU;
            endcase
            r.ctrl.branchKind = BR_COND;
            r.ctrl.branchNeg  = f3[0];
            r.imm2 = 32'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
        end
        // opcode bit 3 splits JAL from JALR
        7'h6f, 7'h67: begin
            bad    = !ins[3] && (f3 != 3'd0);
            useRs1 = !ins[3];
            r.ctrl.aluSrcSel  = SRC_PC_FOUR;
            r.ctrl.branchKind = ins[3] ? BR_JAL : BR_JALR;
            r.ctrl.jump       = 1'b1;
            r.imm1            = pc;
            r.imm2 = ins[3] ? 32'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}))
                            : immI;
        end
        // LUI passes imm2 and AUIPC adds the PC
        7'h37, 7'h17: begin
            useRs1 = 1'b0;
            r.ctrl.aluSrcSel = SRC_IMM1_IMM2;
            r.ctrl.aluOp     = ins[5] ? ALU_PASSB : ALU_ADD;
            r.imm1           = ins[5] ? 32'h0 : pc;
            r.imm2           = {ins[31:12], 12'h000};
        end
        default: bad = 1'b1;
    endcase
    r.ctrl.regWrEn = useRd;
    r.rdAddr  = useRd ? ins[11:7] : 5'd0;
    r.rs1Addr = useRs1 ? ins[19:15] : 5'd0;
    r.rs2Addr = useRs2 ? ins[24:20] : 5'd0;
    // illegal slot keeps its PC and the exception only
    if (bad) begin
        r = '0;
        r.exception = 1'b1;
    end
    r.pc      = pc;
    r.rs1Data = shadowRead(r.rs1Addr, wbEn, wbA, wbD);
    r.rs2Data = shadowRead(r.rs2Addr, wbEn, wbA, wbD);
    r.pcDest  = (r.ctrl.branchKind == BR_JALR) ? ((r.rs1Data + r.imm2) & ~32'h1)
                                               : (pc + r.imm2);
    return r;
endfunction

`endif

// ==== tbIdStage.sv ====
module tbIdStage;
    timeunit 1ns;
    timeprecision 1ps;
    import rv32iPkg::*;

    localparam int numRandom  = 1200;
    // reset, random slots and the directed tail with a wide margin
    localparam int cycleLimit = 2000;

    logic        Clk = 1'b0;
    logic        rstN_i;
    logic [31:0] ifPc_i;
    logic [31:0] ifInstr_i;
    logic        idStall_i;
    logic        idFlush_i;
    logic [4:0]  wbRdAddr_i;
    logic [31:0] wbRdData_i;
    logic        wbRegWrEn_i;
    idOut_t      idOut_o;

    logic [31:0] lcgState   = 32'd67453;
    idOut_t      pending;
    idOut_t      due;
    int          dueSeq     = 0;
    int          checkedSeq = 0;
    int          errCount   = 0;
    int          checkCount = 0;
    int          cycleCount = 0;

    // legal major opcodes for random stimulus
    logic [6:0] legalOps [9] = '{7'h33, 7'h13, 7'h03, 7'h23, 7'h63, 7'h6f, 7'h67,
                                7'h37, 7'h17};

    `include "tbIdModel.svh"

    idStage #(
        .numRegs (32)
    ) u_dut (
        .Clk         (Clk),
        .rstN_i      (rstN_i),
        .ifPc_i      (ifPc_i),
        .ifInstr_i   (ifInstr_i),
        .idStall_i   (idStall_i),
        .idFlush_i   (idFlush_i),
        .wbRdAddr_i  (wbRdAddr_i),
        .wbRdData_i  (wbRdData_i),
        .wbRegWrEn_i (wbRegWrEn_i),
        .idOut_o     (idOut_o)
    );

    always #4 Clk = ~Clk;

    function logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // random fields with funct3/funct7 pulled into a legal combination
    function automatic logic [31:0] legalInstr(input logic [31:0] r, input logic [3:0] sel);
        logic [31:0] ins;
        logic [2:0]  f3;
        logic [3:0]  k;
        k   = sel % 4'd9;
        f3  = r[14:12];
        ins = {r[31:7], legalOps[k]};
        case (k)
            4'd0: ins[31:25] = (r[30] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
            4'd1: begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    ins[31:25] = {1'b0, r[30] && f3[2], 5'b0};
                end
            end
            4'd2: ins[14:12] = (f3 == 3'd3) ? 3'd2 : ((f3 > 3'd5) ? 3'd4 : f3);
            4'd3: ins[14:12] = f3 % 3'd3;
            4'd4: ins[14] = f3[2] | f3[1];
            4'd6: ins[14:12] = 3'd0;
            default: ;
        endcase
        return ins;
    endfunction

    function automatic logic [31:0] illegalInstr(input logic [31:0] r);
        logic [31:0] ins;
        case (r[31:30])
            // low bits other than 11
            2'd0: ins = {r[29:0], 2'b10};
            // system opcode
            2'd1: ins = encI(r[11:0], r[16:12], r[29:27], r[21:17], 7'h73);
            // multiply extension
            2'd2: ins = encR(7'h01, r[4:0], r[9:5], r[29:27], r[14:10]);
            default: ins = encI(r[11:0], r[16:12], 3'd3, r[21:17], 7'h03);
        endcase
        return ins;
    endfunction

    // drive one slot on the current edge and wait for the next one
    task automatic step(input logic [31:0] instr, input logic [31:0] pc,
                        input logic stall, input logic flush, input logic wbEn,
                        input logic [4:0] wbA, input logic [31:0] wbD);
        due = pending;
        dueSeq++;
        ifInstr_i   <= instr;
        ifPc_i      <= pc;
        idStall_i   <= stall;
        idFlush_i   <= flush;
        wbRegWrEn_i <= wbEn;
        wbRdAddr_i  <= wbA;
        wbRdData_i  <= wbD;
        pending = refDecode(instr, pc, stall, flush, due, wbEn, wbA, wbD);
        shadowWrite(wbEn, wbA, wbD);
        @(posedge Clk);
    endtask

    task automatic fieldCheck(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        checkCount++;
        if (exp !== act) begin
            errCount++;
            $display("Fail %s expected 0x%08h actual 0x%08h", name, exp, act);
        end
    endtask

    // ========================================
    // compare at the falling edge
    // ========================================
    always @(negedge Clk) begin
        if (dueSeq != checkedSeq) begin
            checkedSeq = dueSeq;
            fieldCheck("idOut_o.pc", due.pc, idOut_o.pc);
            fieldCheck("idOut_o.ctrl", 32'(due.ctrl), 32'(idOut_o.ctrl));
            fieldCheck("idOut_o.pcDest", due.pcDest, idOut_o.pcDest);
            fieldCheck("idOut_o.imm1", due.imm1, idOut_o.imm1);
            fieldCheck("idOut_o.imm2", due.imm2, idOut_o.imm2);
            fieldCheck("idOut_o.rs1Data", due.rs1Data, idOut_o.rs1Data);
            fieldCheck("idOut_o.rs2Data", due.rs2Data, idOut_o.rs2Data);
            fieldCheck("idOut_o.rdAddr", 32'(due.rdAddr), 32'(idOut_o.rdAddr));
            fieldCheck("idOut_o.rs1Addr", 32'(due.rs1Addr), 32'(idOut_o.rs1Addr));
            fieldCheck("idOut_o.rs2Addr", 32'(due.rs2Addr), 32'(idOut_o.rs2Addr));
            fieldCheck("idOut_o.exception", 32'(due.exception), 32'(idOut_o.exception));
        end
    end

    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout, the run did not finish within %0d cycles", cycleLimit);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] nop;
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] instr;
        logic [31:0] pc;
        nop         = encI(12'h000, 5'd0, 3'd0, 5'd0, 7'h13);
        rstN_i      = 1'b0;
        ifPc_i      = 32'h0;
        ifInstr_i   = 32'h0;
        idStall_i   = 1'b0;
        idFlush_i   = 1'b0;
        wbRdAddr_i  = 5'd0;
        wbRdData_i  = 32'h0;
        wbRegWrEn_i = 1'b0;
        pending     = '0;
        due         = '0;
        for (int i = 0; i < 32; i++) begin
            shadowRegs[i] = 32'h0;
        end
        repeat (10) @(posedge Clk);
        rstN_i <= 1'b1;

        // first slot goes in on the last reset edge so the first check sees the reset NOP
        for (int i = 0; i < numRandom; i++) begin
            r     = nextRand();
            s     = nextRand();
            instr = (r[7:4] == 4'h0) ? illegalInstr(nextRand()) : legalInstr(nextRand(), r[3:0]);
            pc    = nextRand() & 32'hFFFF_FFFC;
            step(instr, pc, s[2:0] == 3'd0, s[6:3] == 4'd0, s[7], s[12:8], nextRand());
        end

        // write-back then read, x0 stays zero, same-cycle forwarding
        step(nop, 32'h100, 1'b0, 1'b0, 1'b1, 5'd5, 32'hCAFE_F00D);
        step(encR(7'h00, 5'd0, 5'd5, 3'd0, 5'd1), 32'h104, 1'b0, 1'b0, 1'b1, 5'd0, 32'hFFFF_FFFF);
        step(encR(7'h00, 5'd0, 5'd0, 3'd0, 5'd2), 32'h108, 1'b0, 1'b0, 1'b0, 5'd0, 32'h0);
        step(encR(7'h20, 5'd7, 5'd7, 3'd0, 5'd3), 32'h10C, 1'b0, 1'b0, 1'b1, 5'd7, 32'h1234_5678);
        // load held over three stalled cycles
        step(encI(12'h010, 5'd5, 3'd2, 5'd4, 7'h03), 32'h110, 1'b0, 1'b0, 1'b0, 5'd0, 32'h0);
        repeat (3) step(encR(7'h00, 5'd4, 5'd7, 3'd6, 5'd6), 32'h114, 1'b1, 1'b0, 1'b0, 5'd0, 32'h0);
        step(encR(7'h00, 5'd4, 5'd7, 3'd6, 5'd6), 32'h114, 1'b0, 1'b0, 1'b0, 5'd0, 32'h0);
        // flush alone, then flush over stall
        step(encI(12'h7FF, 5'd5, 3'd0, 5'd1, 7'h67), 32'h118, 1'b0, 1'b1, 1'b0, 5'd0, 32'h0);
        step(encI(12'h7FF, 5'd5, 3'd0, 5'd1, 7'h67), 32'h11C, 1'b1, 1'b1, 1'b0, 5'd0, 32'h0);
        step(nop, 32'h120, 1'b0, 1'b0, 1'b0, 5'd0, 32'h0);
        step(nop, 32'h124, 1'b0, 1'b0, 1'b0, 5'd0, 32'h0);
        // result of the last slot
        due = pending;
        dueSeq++;
        @(posedge Clk);

        $display("checks %0d, errors %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
rv32iPkg.sv
idControl.sv
idRegFile.sv
branchTargetGen.sv
idStage.sv
tbIdStage.sv

// ==== runSim.sh ====
#!/bin/sh
# build and run the ID stage testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps --top-module tbIdStage \
    -f vlog.f -o simIdStage > build.log 2>&1 &&
./obj_dir/simIdStage > sim.log 2>&1 ||
{ echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "Test failed" sim.log && { echo "FAIL"; exit 1; } || echo "PASS"
